/* logic/core_pkg.sv */
package core_pkg;

    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;
    localparam int NUM_REGS   = 2 ** REG_ADDR_W;

    // major opcodes of the two supported groups
    localparam logic [6:0] OPCODE_OP     = 7'b0110011;
    localparam logic [6:0] OPCODE_OP_IMM = 7'b0010011;

    localparam logic [2:0] F3_ADD = 3'b000;
    localparam logic [2:0] F3_SLL = 3'b001;
    localparam logic [2:0] F3_SLT = 3'b010;
    localparam logic [2:0] F3_XOR = 3'b100;
    localparam logic [2:0] F3_SRL = 3'b101;
    localparam logic [2:0] F3_OR  = 3'b110;
    localparam logic [2:0] F3_AND = 3'b111;

    // funct7 selects sub over add
    localparam logic [6:0] F7_BASE = 7'b0000000;
    localparam logic [6:0] F7_ALT  = 7'b0100000;

    typedef logic [REG_ADDR_W-1:0] reg_idx_t;
    typedef logic [XLEN-1:0]       data_t;

    typedef enum logic [3:0] {
        ALU_ADD = 4'd0,
        ALU_SUB = 4'd1,
        ALU_AND = 4'd2,
        ALU_OR  = 4'd3,
        ALU_XOR = 4'd4,
        ALU_SLT = 4'd5,
        ALU_SLL = 4'd6,
        ALU_SRL = 4'd7
    } alu_op_e;

    typedef struct packed {
        logic [6:0] funct7;
        reg_idx_t   rs2;
        reg_idx_t   rs1;
        logic [2:0] funct3;
        reg_idx_t   rd;
        logic [6:0] opcode;
    } r_type_t;

    typedef struct packed {
        logic [11:0] imm12;
        reg_idx_t    rs1;
        logic [2:0]  funct3;
        reg_idx_t    rd;
        logic [6:0]  opcode;
    } i_type_t;

    // one instruction word, seen as either format
    typedef union packed {
        r_type_t r;
        i_type_t i;
    } inst_word_u;

    typedef struct packed {
        inst_word_u slot0;
        inst_word_u slot1;
    } inst_pair_t;

    typedef struct packed {
        logic     valid;
        logic     writes_rd;
        logic     use_imm;
        alu_op_e  alu_op;
        reg_idx_t rd;
        reg_idx_t rs1;
        reg_idx_t rs2;
        data_t    imm;
    } uop_t;

    typedef struct packed {
        uop_t slot0;
        uop_t slot1;
    } uop_pair_t;

    typedef struct packed {
        uop_t  uop;
        data_t rs1_data;
        data_t rs2_data;
    } exec_lane_t;

    typedef struct packed {
        exec_lane_t lane0;
        exec_lane_t lane1;
    } exec_pair_t;

    typedef struct packed {
        logic     valid;
        logic     writes_rd;
        reg_idx_t rd;
        data_t    data;
    } retire_lane_t;

    // lane 0 is the older instruction
    typedef struct packed {
        retire_lane_t lane0;
        retire_lane_t lane1;
    } retire_pair_t;

endpackage

/* logic/pair_decode.sv */
module pair_decode import core_pkg::*; (
    input  logic       clock_i,
    input  logic       reset_i,

    input  logic       inst_valid_i,
    output logic       inst_ready_o,
    input  inst_pair_t inst_pair_i,

    input  logic       advance_i,
    input  logic       hold_i,
    input  logic       shift_i,

    output logic       dec_valid_o,
    output uop_pair_t  dec_pair_o
);

    logic      dec_valid_q;
    uop_pair_t dec_pair_q;
    logic      accept;

    function automatic uop_t decode_slot(inst_word_u word);
        uop_t uop;
        logic known;
        uop        = '0;
        uop.valid  = 1'b1;
        uop.rd     = word.r.rd;
        uop.alu_op = ALU_ADD;
        known      = 1'b1;
        if (word.r.opcode == OPCODE_OP) begin
            uop.rs1 = word.r.rs1;
            uop.rs2 = word.r.rs2;
            case ({word.r.funct7, word.r.funct3})
                {F7_BASE, F3_ADD}: uop.alu_op = ALU_ADD;
                {F7_ALT,  F3_ADD}: uop.alu_op = ALU_SUB;
                {F7_BASE, F3_AND}: uop.alu_op = ALU_AND;
                {F7_BASE, F3_OR}:  uop.alu_op = ALU_OR;
                {F7_BASE, F3_XOR}: uop.alu_op = ALU_XOR;
                {F7_BASE, F3_SLT}: uop.alu_op = ALU_SLT;
                {F7_BASE, F3_SLL}: uop.alu_op = ALU_SLL;
                {F7_BASE, F3_SRL}: uop.alu_op = ALU_SRL;
                default:           known = 1'b0;
            endcase
        end else if (word.i.opcode == OPCODE_OP_IMM) begin
            uop.rs1     = word.i.rs1;
            uop.use_imm = 1'b1;
            uop.imm     = {{(XLEN-12){word.i.imm12[11]}}, word.i.imm12};
            case (word.i.funct3)
                F3_ADD:  uop.alu_op = ALU_ADD;
                F3_AND:  uop.alu_op = ALU_AND;
                F3_OR:   uop.alu_op = ALU_OR;
                F3_XOR:  uop.alu_op = ALU_XOR;
                F3_SLT:  uop.alu_op = ALU_SLT;
                default: known = 1'b0;
            endcase
        end else begin
            known = 1'b0;
        end
        // anything else reads nothing and retires zero without a write
        if (!known) begin
            uop.rs1     = '0;
            uop.rs2     = '0;
            uop.use_imm = 1'b0;
            uop.imm     = '0;
            uop.alu_op  = ALU_ADD;
        end
        uop.writes_rd = known && (word.r.rd != '0);
        return uop;
    endfunction

    // free, or drained this cycle without a split
    assign inst_ready_o = !dec_valid_q || (advance_i && !hold_i);
    assign accept       = inst_valid_i && inst_ready_o;

    always_ff @(posedge clock_i) begin
        if (reset_i) begin
            dec_valid_q <= 1'b0;
        end else if (accept) begin
            dec_valid_q <= 1'b1;
        end else if (advance_i && !hold_i) begin
            dec_valid_q <= 1'b0;
        end
    end

    always_ff @(posedge clock_i) begin
        if (accept) begin
            dec_pair_q.slot0 <= decode_slot(inst_pair_i.slot0);
            dec_pair_q.slot1 <= decode_slot(inst_pair_i.slot1);
        end else if (shift_i) begin
            // second half of a split pair moves up
            dec_pair_q.slot0 <= dec_pair_q.slot1;
            dec_pair_q.slot1 <= '0;
        end
    end

    assign dec_valid_o = dec_valid_q;
    assign dec_pair_o  = dec_pair_q;

endmodule

/* logic/register_file.sv */
module register_file import core_pkg::*; (
    input  logic          clock_i,
    input  logic          reset_i,

    input  reg_idx_t [3:0] rd_addr_i,
    output data_t    [3:0] rd_data_o,

    input  retire_pair_t  wr_pair_i
);

    data_t regs_q [NUM_REGS];
    logic  we0;
    logic  we1;

    assign we0 = wr_pair_i.lane0.writes_rd && (wr_pair_i.lane0.rd != '0);
    assign we1 = wr_pair_i.lane1.writes_rd && (wr_pair_i.lane1.rd != '0);

    always_ff @(posedge clock_i) begin
        if (reset_i) begin
            for (int r = 0; r < NUM_REGS; r++) begin
                regs_q[r] <= '0;
            end
        end else begin
            if (we0) begin
                regs_q[wr_pair_i.lane0.rd] <= wr_pair_i.lane0.data;
            end
            // lane 1 is younger, so it lands last
            if (we1) begin
                regs_q[wr_pair_i.lane1.rd] <= wr_pair_i.lane1.data;
            end
        end
    end

    always_comb begin
        for (int p = 0; p < 4; p++) begin
            rd_data_o[p] = regs_q[rd_addr_i[p]];
            if (we0 && wr_pair_i.lane0.rd == rd_addr_i[p]) begin
                rd_data_o[p] = wr_pair_i.lane0.data;
            end
            if (we1 && wr_pair_i.lane1.rd == rd_addr_i[p]) begin
                rd_data_o[p] = wr_pair_i.lane1.data;
            end
            if (rd_addr_i[p] == '0) begin
                rd_data_o[p] = '0;
            end
        end
    end

endmodule

/* logic/pair_issue.sv */
module pair_issue import core_pkg::*; (
    input  logic           clock_i,
    input  logic           reset_i,
    input  logic           advance_i,

    input  logic           dec_valid_i,
    input  uop_pair_t      dec_pair_i,

    output logic           hold_o,
    output logic           shift_o,

    output reg_idx_t [3:0] rf_addr_o,
    input  data_t    [3:0] rf_data_i,

    output exec_pair_t     exec_pair_o
);

    uop_t       slot0;
    uop_t       slot1;
    logic       dep;
    exec_pair_t exec_d;
    exec_pair_t exec_q;

    assign slot0 = dec_pair_i.slot0;
    assign slot1 = dec_pair_i.slot1;

    // operand read ports, two per slot
    assign rf_addr_o[0] = slot0.rs1;
    assign rf_addr_o[1] = slot0.rs2;
    assign rf_addr_o[2] = slot1.rs1;
    assign rf_addr_o[3] = slot1.rs2;

    // writes_rd is already clear for rd x0
    always_comb begin
        dep = 1'b0;
        if (slot0.valid && slot1.valid && slot0.writes_rd) begin
            dep = (slot1.rs1 == slot0.rd) || (slot1.rs2 == slot0.rd);
        end
    end

    assign hold_o  = dec_valid_i && dep;
    assign shift_o = hold_o && advance_i;

    always_comb begin
        exec_d.lane0.uop      = slot0;
        exec_d.lane0.rs1_data = rf_data_i[0];
        exec_d.lane0.rs2_data = rf_data_i[1];
        exec_d.lane1.uop      = slot1;
        exec_d.lane1.rs1_data = rf_data_i[2];
        exec_d.lane1.rs2_data = rf_data_i[3];

        exec_d.lane0.uop.valid = dec_valid_i && slot0.valid;
        // on a split slot 0 goes alone
        exec_d.lane1.uop.valid = dec_valid_i && slot1.valid && !dep;
    end

    always_ff @(posedge clock_i) begin
        if (reset_i) begin
            exec_q.lane0.uop.valid <= 1'b0;
            exec_q.lane1.uop.valid <= 1'b0;
        end else if (advance_i) begin
            exec_q <= exec_d;
        end
    end

    assign exec_pair_o = exec_q;

endmodule

/* logic/execute.sv */
module execute import core_pkg::*; (
    input  exec_pair_t   exec_pair_i,
    input  retire_pair_t wb_pair_i,
    output retire_pair_t result_pair_o
);

    // newest writer in the writeback register wins
    function automatic data_t forward(reg_idx_t src, data_t rf_val, retire_pair_t wb);
        data_t val;
        val = rf_val;
        if (src != '0) begin
            if (wb.lane0.writes_rd && wb.lane0.rd == src) begin
                val = wb.lane0.data;
            end
            if (wb.lane1.writes_rd && wb.lane1.rd == src) begin
                val = wb.lane1.data;
            end
        end
        return val;
    endfunction

    function automatic data_t alu(alu_op_e op, data_t a, data_t b);
        data_t res;
        case (op)
            ALU_ADD: res = a + b;
            ALU_SUB: res = a - b;
            ALU_AND: res = a & b;
            ALU_OR:  res = a | b;
            ALU_XOR: res = a ^ b;
            ALU_SLT: res = {{(XLEN-1){1'b0}}, $signed(a) < $signed(b)};
            // shift amount is the low five bits only
            ALU_SLL: res = a << b[4:0];
            ALU_SRL: res = a >> b[4:0];
            default: res = '0;
        endcase
        return res;
    endfunction

    function automatic retire_lane_t run_lane(exec_lane_t lane, retire_pair_t wb);
        retire_lane_t res;
        data_t        op_a;
        data_t        op_b;
        op_a = forward(lane.uop.rs1, lane.rs1_data, wb);
        op_b = forward(lane.uop.rs2, lane.rs2_data, wb);
        if (lane.uop.use_imm) begin
            op_b = lane.uop.imm;
        end
        res.valid     = lane.uop.valid;
        res.writes_rd = lane.uop.valid && lane.uop.writes_rd;
        res.rd        = lane.uop.rd;
        res.data      = alu(lane.uop.alu_op, op_a, op_b);
        return res;
    endfunction

    always_comb begin
        result_pair_o.lane0 = run_lane(exec_pair_i.lane0, wb_pair_i);
        result_pair_o.lane1 = run_lane(exec_pair_i.lane1, wb_pair_i);
    end

endmodule

/* logic/retire_stage.sv */
module retire_stage import core_pkg::*; (
    input  logic         clock_i,
    input  logic         reset_i,

    input  retire_pair_t result_pair_i,

    input  logic         retire_ready_i,
    output logic         retire_valid_o,
    output retire_pair_t retire_pair_o,

    output logic         advance_o,
    output retire_pair_t wr_pair_o
);

    retire_pair_t wb_q;
    logic         retire_fire;

    // an all-invalid pair loads as empty, so it is never offered
    assign retire_valid_o = wb_q.lane0.valid || wb_q.lane1.valid;
    assign retire_fire    = retire_valid_o && retire_ready_i;
    assign advance_o      = !retire_valid_o || retire_ready_i;
    assign retire_pair_o  = wb_q;

    always_ff @(posedge clock_i) begin
        if (reset_i) begin
            wb_q.lane0.valid <= 1'b0;
            wb_q.lane1.valid <= 1'b0;
        end else if (advance_o) begin
            wb_q <= result_pair_i;
        end
    end

    // register writes only on the retire transfer
    always_comb begin
        wr_pair_o                 = wb_q;
        wr_pair_o.lane0.writes_rd = retire_fire && wb_q.lane0.valid && wb_q.lane0.writes_rd;
        wr_pair_o.lane1.writes_rd = retire_fire && wb_q.lane1.valid && wb_q.lane1.writes_rd;
    end

endmodule

/* logic/dual_core.sv */
module dual_core import core_pkg::*; (
    input  logic         clock_i,
    input  logic         reset_i,

    input  logic         inst_valid_i,
    output logic         inst_ready_o,
    input  inst_pair_t   inst_pair_i,

    output logic         retire_valid_o,
    input  logic         retire_ready_i,
    output retire_pair_t retire_pair_o
);

    logic           advance;
    logic           hold;
    logic           shift;
    logic           dec_valid;
    uop_pair_t      dec_pair;
    reg_idx_t [3:0] rf_addr;
    data_t    [3:0] rf_data;
    exec_pair_t     exec_pair;
    retire_pair_t   result_pair;
    retire_pair_t   wr_pair;

    pair_decode i_decode (
        .clock_i      (clock_i),
        .reset_i      (reset_i),
        .inst_valid_i (inst_valid_i),
        .inst_ready_o (inst_ready_o),
        .inst_pair_i  (inst_pair_i),
        .advance_i    (advance),
        .hold_i       (hold),
        .shift_i      (shift),
        .dec_valid_o  (dec_valid),
        .dec_pair_o   (dec_pair)
    );

    pair_issue i_issue (
        .clock_i     (clock_i),
        .reset_i     (reset_i),
        .advance_i   (advance),
        .dec_valid_i (dec_valid),
        .dec_pair_i  (dec_pair),
        .hold_o      (hold),
        .shift_o     (shift),
        .rf_addr_o   (rf_addr),
        .rf_data_i   (rf_data),
        .exec_pair_o (exec_pair)
    );

    register_file i_regfile (
        .clock_i   (clock_i),
        .reset_i   (reset_i),
        .rd_addr_i (rf_addr),
        .rd_data_o (rf_data),
        .wr_pair_i (wr_pair)
    );

    // writeback register feeds back for forwarding
    execute i_execute (
        .exec_pair_i   (exec_pair),
        .wb_pair_i     (retire_pair_o),
        .result_pair_o (result_pair)
    );

    retire_stage i_retire (
        .clock_i        (clock_i),
        .reset_i        (reset_i),
        .result_pair_i  (result_pair),
        .retire_ready_i (retire_ready_i),
        .retire_valid_o (retire_valid_o),
        .retire_pair_o  (retire_pair_o),
        .advance_o      (advance),
        .wr_pair_o      (wr_pair)
    );

endmodule

/* verif/tb_dual_core.sv */
module tb_dual_core import core_pkg::*; ();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int    CLK_PERIOD = 8;
    localparam string TRACE_FILE = "verif/dual_core_trace.txt";

    logic         clock;
    logic         reset;
    logic         inst_valid;
    logic         inst_ready;
    inst_pair_t   inst_pair;
    logic         retire_valid;
    logic         retire_ready;
    retire_pair_t retire_pair;

    inst_pair_t   pair_q[$];
    retire_lane_t exp_q[$];
    int           trace_lines;
    int           total_recs;
    int           checked_recs;
    int           value_errors;
    int           other_errors;
    logic [31:0]  rng_state;
    bit           loaded;

    dual_core i_dut (
        .clock_i        (clock),
        .reset_i        (reset),
        .inst_valid_i   (inst_valid),
        .inst_ready_o   (inst_ready),
        .inst_pair_i    (inst_pair),
        .retire_valid_o (retire_valid),
        .retire_ready_i (retire_ready),
        .retire_pair_o  (retire_pair)
    );

    initial begin
        clock = 1'b0;
        forever begin
            #(CLK_PERIOD / 2) clock = ~clock;
        end
    end

    function automatic logic [31:0] xorshift32(logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // I lines feed pairs, E lines hold retire records in program order
    task automatic read_trace();
        int           fd;
        int           n;
        string        line;
        string        rest;
        logic [31:0]  f0;
        logic [31:0]  f1;
        logic [31:0]  f2;
        inst_pair_t   p;
        retire_lane_t e;
        fd = $fopen(TRACE_FILE, "r");
        if (fd == 0) begin
            $display("could not open the trace file %s", TRACE_FILE);
            other_errors++;
            return;
        end
        while (!$feof(fd)) begin
            line = "";
            n = $fgets(line, fd);
            if (line.len() < 2 || line.getc(0) == "#") begin
                continue;
            end
            trace_lines++;
            rest = line.substr(1, line.len() - 1);
            if (line.getc(0) == "I") begin
                n = $sscanf(rest, "%h %h", f0, f1);
                p = {f0, f1};
                pair_q.push_back(p);
            end else if (line.getc(0) == "E") begin
                n = $sscanf(rest, "%h %h %h", f0, f1, f2);
                e.valid     = 1'b1;
                e.rd        = f0[4:0];
                e.writes_rd = f1[0];
                e.data      = f2;
                exp_q.push_back(e);
            end else begin
                $display("unrecognized trace line: %s", line);
                other_errors++;
            end
        end
        $fclose(fd);
        if (exp_q.size() != 2 * pair_q.size()) begin
            $display("trace holds %0d pairs but %0d expected records",
                     pair_q.size(), exp_q.size());
            other_errors++;
        end
    endtask

    task automatic check_lane(input retire_lane_t act);
        retire_lane_t exp;
        if (exp_q.size() == 0) begin
            $display("a record for x%0d retired after the last expected record", act.rd);
            other_errors++;
            return;
        end
        exp = exp_q.pop_front();
        checked_recs++;
        assert (act.rd == exp.rd) else begin
            $display("** Error retire_pair_o.rd (record %0d): expected %h got %h",
                     checked_recs, exp.rd, act.rd);
            value_errors++;
        end
        assert (act.writes_rd == exp.writes_rd) else begin
            $display("** Error retire_pair_o.writes_rd (record %0d): expected %h got %h",
                     checked_recs, exp.writes_rd, act.writes_rd);
            value_errors++;
        end
        // data of a lane that does not write is not defined
        assert (!exp.writes_rd || act.data == exp.data) else begin
            $display("** Error retire_pair_o.data (record %0d): expected %h got %h",
                     checked_recs, exp.data, act.data);
            value_errors++;
        end
    endtask

    task automatic print_summary();
        $display("records checked %0d of %0d, value errors %0d, other errors %0d",
                 checked_recs, total_recs, value_errors, other_errors);
    endtask

    initial begin
        retire_pair_t held_pair;
        logic         stalled;
        logic         in_fire;
        logic         fill_in_stall;
        reset        = 1'b1;
        inst_valid   = 1'b0;
        inst_pair    = '0;
        retire_ready = 1'b0;
        rng_state    = 32'd5347;
        read_trace();
        total_recs    = exp_q.size();
        loaded        = 1'b1;
        held_pair     = '0;
        stalled       = 1'b0;
        fill_in_stall = 1'b0;
        repeat (10) @(posedge clock);
        #1;
        reset = 1'b0;
        // empty pipeline after reset
        assert (inst_ready == 1'b1) else begin
            $display("** Error inst_ready_o: expected 1 got %h after reset", inst_ready);
            value_errors++;
        end
        assert (retire_valid == 1'b0) else begin
            $display("** Error retire_valid_o: expected 0 got %h after reset", retire_valid);
            value_errors++;
        end
        while (pair_q.size() > 0 || exp_q.size() > 0) begin
            rng_state = xorshift32(rng_state);
            // a new pair only once the last one was taken
            if (!inst_valid && pair_q.size() > 0 && rng_state[4:3] != 2'b00) begin
                inst_valid = 1'b1;
                inst_pair  = pair_q.pop_front();
            end
            retire_ready = (rng_state[1:0] != 2'b00);
            @(negedge clock);
            if (stalled) begin
                assert (retire_valid) else begin
                    $display("** Error retire_valid_o: expected 1 got %h while stalled",
                             retire_valid);
                    value_errors++;
                end
                assert (retire_pair == held_pair) else begin
                    $display("** Error retire_pair_o: expected %h got %h while stalled",
                             held_pair, retire_pair);
                    value_errors++;
                end
            end
            // decode stage filled during the stall cannot drain
            if (fill_in_stall && retire_valid && !retire_ready) begin
                assert (!inst_ready) else begin
                    $display("** Error inst_ready_o: expected 0 got %h with decode full",
                             inst_ready);
                    value_errors++;
                end
            end
            stalled       = retire_valid && !retire_ready;
            held_pair     = retire_pair;
            in_fire       = inst_valid && inst_ready;
            fill_in_stall = stalled && (fill_in_stall || in_fire);
            if (retire_valid && retire_ready) begin
                if (retire_pair.lane0.valid) begin
                    check_lane(retire_pair.lane0);
                end
                if (retire_pair.lane1.valid) begin
                    check_lane(retire_pair.lane1);
                end
            end
            @(posedge clock);
            #1;
            if (in_fire) begin
                inst_valid = 1'b0;
            end
        end
        // pipeline must stay empty
        retire_ready = 1'b1;
        repeat (4) begin
            @(negedge clock);
            if (retire_valid) begin
                $display("the DUT retired a pair after the last expected record");
                other_errors++;
            end
        end
        print_summary();
        if (value_errors == 0 && other_errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

    initial begin
        wait (loaded);
        repeat (trace_lines * 40 + 100) @(posedge clock);
        $display("timeout after %0d cycles with %0d expected records not retired",
                 trace_lines * 40 + 100, exp_q.size());
        print_summary();
        $display("Checks failed");
        $finish;
    end

endmodule

/* verif/dual_core_trace.txt */
# I <slot0 word> <slot1 word>, one input pair, fed in order
# E <rd> <writes> <data>, retire records in program order, data checked only when writes is 1
I 12300093 FFB00113
E 01 1 00000123
E 02 1 FFFFFFFB
I 002081B3 40110233
E 03 1 0000011E
E 04 1 FFFFFED8
I 401002B3 00322333
E 05 1 FFFFFEDD
E 06 1 00000001
I 02400393 00709433
E 07 1 00000024
E 08 1 00001230
I 007154B3 0022F533
E 09 1 0FFFFFFF
E 0A 1 FFFFFED9
I 0080E5B3 0054C5B3
E 0B 1 00001333
E 0B 1 F0000122
I 7F05F693 F000E713
E 0D 1 00000120
E 0E 1 FFFFFF23
I FFF74793 EDE2A813
E 0F 1 000000DC
E 10 1 00000001
I 00508013 00F008B3
E 00 0 00000128
E 11 1 000000DC
I 0000088B 00088933
E 11 0 00000000
E 12 1 000000DC

/* src.f */
logic/core_pkg.sv
logic/pair_decode.sv
logic/register_file.sv
logic/pair_issue.sv
logic/execute.sv
logic/retire_stage.sv
logic/dual_core.sv
verif/tb_dual_core.sv

/* Makefile */
SIM      := verilator
FLAGS    := --binary --assert --timescale 1ns/100ps -j 0
TOP      := tb_dual_core
FILELIST := src.f

SOURCES  := $(shell grep -v '^+' $(FILELIST))
BIN      := obj_dir/V$(TOP)
LOG      := sim.log

.PHONY: all run clean

all: run

$(BIN): $(FILELIST) $(SOURCES)
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	@grep -q "^All checks passed$$" $(LOG) && echo "PASS" || (echo "FAIL" && exit 1)

clean:
	rm -rf obj_dir $(LOG)
